// ==== cam_display_top.f ====
+incdir+include
hdl/pixel_pkg.sv
hdl/scan_timer.sv
hdl/display_enable_fsm.sv
hdl/frame_buffer.sv
hdl/pixel_pipeline.sv
hdl/cam_display_top.sv
testbench/cam_display_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal -f cam_display_top.f \
       --top-module cam_display_tb -o cam_display_sim \
  && ./obj_dir/cam_display_sim | tee /dev/stderr | grep -qx "RESULT: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== testbench/cam_display_tb.sv ====
`timescale 1ns/1ps
`include "cam_display_params.svh"

module cam_display_tb;

    localparam int NUM_PIX    = `IMG_WIDTH * `IMG_HEIGHT;
    localparam int FRAME_CLKS = `H_TOTAL * `V_TOTAL;
    localparam int NUM_ROWS   = 6;

    logic               clk_25MHz;
    logic               rst_n;
    logic               wr_en;
    logic               frame_ready;
    logic               vga_enable;
    logic               pixel_valid;
    logic [`ADDR_W-1:0] wr_addr;
    logic [`PIX_W-1:0]  wr_data;
    logic [`MODE_W-1:0] filter_mode;
    logic [`CH_W-1:0]   red;
    logic [`CH_W-1:0]   green;
    logic [`CH_W-1:0]   blue;

    // ====================
    // stimulus table of mode, frames to check and frame_ready level
    // ====================
    logic [`MODE_W-1:0] row_mode [NUM_ROWS] =
        '{`MODE_ORIG, `MODE_ORIG, `MODE_GRAY, 3'd5, `MODE_GRAY, `MODE_ORIG};
    int   row_frames [NUM_ROWS] = '{2, 3, 2, 2, 2, 2};
    logic row_ready  [NUM_ROWS] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};

    // local copy of the frame buffer contents
    logic [`PIX_W-1:0] image [NUM_PIX];
    logic [15:0]       lfsr_state = 16'd29221;
    int   cycle_cnt    = 0;
    int   cycle_limit  = 0;
    int   errors       = 0;
    int   rise_mark    = 0;
    int   fall_mark    = 0;
    int   pix_idx      = 0;
    int   run_len      = 0;
    int   gap_len      = 0;
    int   frame_pulses = 0;
    int   frames_seen  = 0;
    logic fill_done    = 1'b0;
    logic check_en     = 1'b0;
    logic rise_pending = 1'b0;
    logic drop_armed   = 1'b0;

    cam_display_top UUT (.*);

    // 40 ns period
    initial begin
        clk_25MHz = 1'b0;
        forever #20 clk_25MHz = ~clk_25MHz;
    end

    // galois step with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // expected rgb888 or gray triple of one stored word
    function automatic logic [23:0] expected_rgb(input logic [15:0] w,
                                                 input logic [`MODE_W-1:0] mode);
        logic [7:0] r8;
        logic [7:0] g8;
        logic [7:0] b8;
        int         gray;
        r8   = {w[15:11], 3'b111};
        g8   = {w[10:5], 2'b11};
        b8   = {w[4:0], 3'b111};
        gray = (int'(r8) * `GRAY_R_WT + int'(g8) * `GRAY_G_WT + int'(b8) * `GRAY_B_WT) >> 8;
        return (mode == `MODE_GRAY) ? {3{gray[7:0]}} : {r8, g8, b8};
    endfunction

    task automatic stop_on_failure();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first failed check");
    endtask

    task automatic report_mismatch(input string msg);
        errors++;
        $display("FAILED at %0d ns: %s", $time, msg);
        stop_on_failure();
    endtask

    // ====================
    // stimulus
    // ====================
    initial begin : stimulus
        logic [15:0] word;
        int          target;
        rst_n       = 1'b0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        frame_ready = 1'b0;
        filter_mode = `MODE_ORIG;
        foreach (row_frames[r]) cycle_limit += row_frames[r] * FRAME_CLKS;
        cycle_limit += 400;
        repeat (3) @(posedge clk_25MHz);
        #2 rst_n = 1'b1;
        // fill starts with the scan, so writes stay ahead of reads
        for (int a = 0; a < NUM_PIX; a++) begin
            word = '0;
            for (int b = 0; b < 16; b++) begin
                word       = {word[14:0], lfsr_state[0]};
                lfsr_state = lfsr_step(lfsr_state);
            end
            image[a] = word;
            wr_en    = 1'b1;
            wr_addr  = `ADDR_W'(a);
            wr_data  = word;
            @(posedge clk_25MHz);
            #2;
        end
        wr_en     = 1'b0;
        fill_done = 1'b1;
        foreach (row_mode[r]) begin
            // ready edges start the enable timing checks
            if (row_ready[r] && !frame_ready) begin
                rise_mark    = cycle_cnt;
                rise_pending = 1'b1;
            end
            if (!row_ready[r] && frame_ready) begin
                assert (vga_enable) else report_mismatch("vga_enable low before ready drop");
                fall_mark  = cycle_cnt;
                drop_armed = 1'b1;
            end
            frame_ready = row_ready[r];
            filter_mode = row_mode[r];
            target      = frames_seen + row_frames[r];
            wait (frames_seen >= target);
            // in vblank here after a full line without pixels
            @(posedge clk_25MHz);
            #2;
        end
        if (errors == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

    // ====================
    // output monitor on the falling edge
    // ====================
    always @(negedge clk_25MHz) begin : monitor
        logic [23:0] exp_rgb;
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: test did not finish within %0d clock cycles", cycle_limit);
            stop_on_failure();
        end else if (!rst_n) begin
            assert (!vga_enable && !pixel_valid && {red, green, blue} == '0)
                else report_mismatch("outputs high in reset");
        end else begin
            assert (pixel_valid || {red, green, blue} == '0)
                else report_mismatch("colour not black while pixel_valid low");
            // rise within a frame plus sync and fall 3 clocks after ready drops
            if (frame_ready) begin
                if (vga_enable) rise_pending = 1'b0;
                assert (!rise_pending || cycle_cnt - rise_mark <= FRAME_CLKS + 3) else begin
                    $display("vga_enable did not rise within one frame of frame_ready");
                    stop_on_failure();
                end
                assert (rise_pending || vga_enable)
                    else report_mismatch("vga_enable fell while frame_ready high");
            end else if (drop_armed && cycle_cnt - fall_mark < 4) begin
                assert (vga_enable) else report_mismatch("vga_enable fell too early");
            end else begin
                assert (!vga_enable) else report_mismatch("vga_enable high, frame_ready low");
            end
            // pulse count gives the address on the outputs
            if (pixel_valid) begin
                if (fill_done && pix_idx == 0) check_en = 1'b1;
                exp_rgb = expected_rgb(image[pix_idx], filter_mode);
                assert (!check_en || {red, green, blue} == exp_rgb)
                    else report_mismatch($sformatf("pixel %0d mode %0d got %h expected %h",
                        pix_idx, filter_mode, {red, green, blue}, exp_rgb));
                pix_idx = (pix_idx + 1) % NUM_PIX;
                run_len++;
                frame_pulses++;
                gap_len = 0;
            end else begin
                assert (run_len == 0 || run_len == `IMG_WIDTH)
                    else report_mismatch($sformatf("run of %0d valid pixels", run_len));
                run_len = 0;
                gap_len++;
                // a blank line marks the end of a frame
                if (gap_len == `H_TOTAL && frame_pulses != 0) begin
                    assert (frame_pulses == NUM_PIX)
                        else report_mismatch($sformatf("%0d pixels in frame", frame_pulses));
                    frame_pulses = 0;
                    frames_seen++;
                end
            end
        end
    end

endmodule

// ==== hdl/cam_display_top.sv ====
`timescale 1ns/1ps
`include "cam_display_params.svh"

module cam_display_top (
    input  logic               clk_25MHz,
    input  logic               rst_n,
    // external write port, no handshake
    input  logic               wr_en,
    input  logic [`ADDR_W-1:0] wr_addr,
    input  logic [`PIX_W-1:0]  wr_data,
    // async level from the capture side
    input  logic               frame_ready,
    input  logic [`MODE_W-1:0] filter_mode,
    output logic               vga_enable,
    output logic               pixel_valid,
    output logic [`CH_W-1:0]   red,
    output logic [`CH_W-1:0]   green,
    output logic [`CH_W-1:0]   blue
);

    // ====================
    // internal wires
    // ====================
    logic               active;
    logic [`ADDR_W-1:0] pixel_addr;
    logic               vsync_n;
    pixel_pkg::rgb565_t rd_data;

    // raster position and sync
    scan_timer u_scan_timer (
        .clk_25MHz  (clk_25MHz),
        .rst_n      (rst_n),
        .active     (active),
        .pixel_addr (pixel_addr),
        .vsync_n    (vsync_n)
    );

    // display on at the frame boundary
    display_enable_fsm u_display_enable_fsm (
        .clk_25MHz   (clk_25MHz),
        .rst_n       (rst_n),
        .frame_ready (frame_ready),
        .vsync_n     (vsync_n),
        .vga_enable  (vga_enable)
    );

    // rgb565 pixel store, read by scan address
    frame_buffer u_frame_buffer (
        .clk_25MHz (clk_25MHz),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (pixel_addr),
        .rd_data   (rd_data)
    );

    // expansion, gray and output registers
    pixel_pipeline u_pixel_pipeline (
        .clk_25MHz   (clk_25MHz),
        .rst_n       (rst_n),
        .active      (active),
        .rd_data     (rd_data),
        .filter_mode (filter_mode),
        .pixel_valid (pixel_valid),
        .red         (red),
        .green       (green),
        .blue        (blue)
    );

endmodule

// ==== hdl/pixel_pipeline.sv ====
`timescale 1ns/1ps
`include "cam_display_params.svh"

module pixel_pipeline (
    input  logic               clk_25MHz,
    input  logic               rst_n,
    input  logic               active,
    input  pixel_pkg::rgb565_t rd_data,
    input  logic [`MODE_W-1:0] filter_mode,
    output logic               pixel_valid,
    output logic [`CH_W-1:0]   red,
    output logic [`CH_W-1:0]   green,
    output logic [`CH_W-1:0]   blue
);

    // active delayed to meet memory data
    logic [`MEM_RD_LAT-1:0] active_dly;
    logic                   active_aligned;

    // rgb888 from the stored word
    logic [`CH_W-1:0] r8;
    logic [`CH_W-1:0] g8;
    logic [`CH_W-1:0] b8;

    // weighted sum and its top byte
    logic [2*`CH_W-1:0] gray_sum;
    logic [`CH_W-1:0]   gray;

    // selected colour before the output register
    logic [`CH_W-1:0] sel_r;
    logic [`CH_W-1:0] sel_g;
    logic [`CH_W-1:0] sel_b;

    // ====================
    // active alignment
    // ====================
    always_ff @(posedge clk_25MHz or negedge rst_n) begin
        if (!rst_n) begin
            active_dly <= '0;
        end else begin
            active_dly <= {active_dly[`MEM_RD_LAT-2:0], active};
        end
    end

    assign active_aligned = active_dly[`MEM_RD_LAT-1];

    // ====================
    // colour expansion
    // ====================
    // pad low bits with ones
    assign r8 = {rd_data.rgb.r, 3'b111};
    assign g8 = {rd_data.rgb.g, 2'b11};
    assign b8 = {rd_data.rgb.b, 3'b111};

    // weights sum to 252, so 16 bits never overflow
    assign gray_sum = r8 * 16'(`GRAY_R_WT)
                    + g8 * 16'(`GRAY_G_WT)
                    + b8 * 16'(`GRAY_B_WT);
    assign gray     = gray_sum[2*`CH_W-1:`CH_W];

    // ====================
    // mode select
    // ====================
    always_comb begin
        if (!active_aligned) begin
            // black in blanking
            sel_r = '0;
            sel_g = '0;
            sel_b = '0;
        end else if (filter_mode == `MODE_GRAY) begin
            sel_r = gray;
            sel_g = gray;
            sel_b = gray;
        end else begin
            // orig and any unused code
            sel_r = r8;
            sel_g = g8;
            sel_b = b8;
        end
    end

    // output registers
    always_ff @(posedge clk_25MHz or negedge rst_n) begin
        if (!rst_n) begin
            pixel_valid <= 1'b0;
            red         <= '0;
            green       <= '0;
            blue        <= '0;
        end else begin
            pixel_valid <= active_aligned;
            red         <= sel_r;
            green       <= sel_g;
            blue        <= sel_b;
        end
    end

    // valid trails the scan flag by the full path latency
    valid_latency: assert property (
        @(posedge clk_25MHz) disable iff (!rst_n)
        pixel_valid == $past(active, `PIPE_LATENCY)
    );

endmodule

// ==== hdl/frame_buffer.sv ====
`timescale 1ns/1ps
`include "cam_display_params.svh"

module frame_buffer (
    input  logic               clk_25MHz,
    input  logic               wr_en,
    input  logic [`ADDR_W-1:0] wr_addr,
    input  pixel_pkg::rgb565_t wr_data,
    input  logic [`ADDR_W-1:0] rd_addr,
    output pixel_pkg::rgb565_t rd_data
);

    localparam int DEPTH = 1 << `ADDR_W;

    // single bank, one word per pixel
    logic [`PIX_W-1:0]  mem [0:DEPTH-1];
    logic [`ADDR_W-1:0] rd_addr_q;

    // ====================
    // write port
    // ====================
    always_ff @(posedge clk_25MHz) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data.raw;
        end
    end

    // ====================
    // two stage read
    // ====================
    always_ff @(posedge clk_25MHz) begin
        // stage 1 address register
        rd_addr_q <= rd_addr;
        // stage 2 data register
        rd_data.raw <= mem[rd_addr_q];
    end

    // a written word is seen by the next memory read of its address
    wr_then_rd: assert property (
        @(posedge clk_25MHz)
        $past(wr_en) && (rd_addr_q == $past(wr_addr)) |=> rd_data.raw == $past(wr_data.raw, 2)
    );

endmodule

// ==== hdl/display_enable_fsm.sv ====
`timescale 1ns/1ps
`include "cam_display_params.svh"

module display_enable_fsm (
    input  logic clk_25MHz,
    input  logic rst_n,
    input  logic frame_ready,
    input  logic vsync_n,
    output logic vga_enable
);

    // state codes
    localparam logic [1:0] WAIT_FRAME = 2'd0;
    localparam logic [1:0] WAIT_VSYNC = 2'd1;
    localparam logic [1:0] DISPLAY    = 2'd2;

    logic       ready_sync1;
    logic       ready_sync2;
    logic       vsync_prev;
    logic       vsync_rise;
    logic [1:0] state;

    // ====================
    // frame_ready synchronizer
    // ====================
    always_ff @(posedge clk_25MHz or negedge rst_n) begin
        if (!rst_n) begin
            ready_sync1 <= 1'b0;
            ready_sync2 <= 1'b0;
            vsync_prev  <= 1'b1;
        end else begin
            ready_sync1 <= frame_ready;
            ready_sync2 <= ready_sync1;
            vsync_prev  <= vsync_n;
        end
    end

    // end of the vsync pulse
    assign vsync_rise = !vsync_prev && vsync_n;

    // ====================
    // enable state machine
    // ====================
    always_ff @(posedge clk_25MHz or negedge rst_n) begin
        if (!rst_n) begin
            state <= WAIT_FRAME;
        end else if (!ready_sync2) begin
            // lost ready, drop back from any state
            state <= WAIT_FRAME;
        end else begin
            case (state)
                // ready seen, edge may already be here
                WAIT_FRAME: state <= vsync_rise ? DISPLAY : WAIT_VSYNC;
                WAIT_VSYNC: state <= vsync_rise ? DISPLAY : WAIT_VSYNC;
                DISPLAY:    state <= DISPLAY;
                default:    state <= WAIT_FRAME;
            endcase
        end
    end

    assign vga_enable = (state == DISPLAY);

    // display only follows a synchronized ready level
    enable_needs_ready: assert property (
        @(posedge clk_25MHz) disable iff (!rst_n)
        vga_enable |-> $past(ready_sync2)
    );

endmodule

// ==== hdl/scan_timer.sv ====
`timescale 1ns/1ps
`include "cam_display_params.svh"

module scan_timer (
    input  logic              clk_25MHz,
    input  logic              rst_n,
    output logic              active,
    output logic [`ADDR_W-1:0] pixel_addr,
    output logic              vsync_n
);

    localparam int COL_W  = $clog2(`H_TOTAL);
    localparam int LINE_W = $clog2(`V_TOTAL);

    // current raster position
    logic [COL_W-1:0]  col;
    logic [LINE_W-1:0] line;
    logic              in_image;

    // ====================
    // raster counters
    // ====================
    always_ff @(posedge clk_25MHz or negedge rst_n) begin
        if (!rst_n) begin
            col  <= '0;
            line <= '0;
        end else if (col == COL_W'(`H_TOTAL - 1)) begin
            // end of line wraps column and steps line
            col <= '0;
            if (line == LINE_W'(`V_TOTAL - 1)) begin
                line <= '0;
            end else begin
                line <= line + 1'b1;
            end
        end else begin
            col <= col + 1'b1;
        end
    end

    // inside the 16 x 8 visible window
    assign in_image = (col < COL_W'(`IMG_WIDTH)) && (line < LINE_W'(`IMG_HEIGHT));

    // ====================
    // registered scan outputs
    // ====================
    always_ff @(posedge clk_25MHz or negedge rst_n) begin
        if (!rst_n) begin
            active     <= 1'b0;
            pixel_addr <= '0;
            vsync_n    <= 1'b1;
        end else begin
            active <= in_image;
            // line * width + column and parked at 0 in blanking
            pixel_addr <= in_image ? `ADDR_W'(line * `IMG_WIDTH + col) : '0;
            vsync_n    <= (line != LINE_W'(`VSYNC_LINE));
        end
    end

    // address steps by one along each visible run
    addr_steps_in_line: assert property (
        @(posedge clk_25MHz) disable iff (!rst_n)
        active && $past(active) |-> pixel_addr == $past(pixel_addr) + 1'b1
    );

endmodule

// ==== hdl/pixel_pkg.sv ====
`include "cam_display_params.svh"

package pixel_pkg;

    // one stored pixel word, seen either raw or as rgb565 fields
    typedef union packed {
        // raw word as written and stored
        logic [`PIX_W-1:0] raw;
        // channel view, red in the top bits
        struct packed {
            logic [4:0] r;
            logic [5:0] g;
            logic [4:0] b;
        } rgb;
    } rgb565_t;

endpackage

// ==== include/cam_display_params.svh ====
`ifndef CAM_DISPLAY_PARAMS_SVH
`define CAM_DISPLAY_PARAMS_SVH

// ====================
// image geometry
// ====================
`define IMG_WIDTH    16
`define IMG_HEIGHT   8

// raster frame incl. blanking
`define H_TOTAL      20
`define V_TOTAL      10
// vsync low for this whole line
`define VSYNC_LINE   9

// ====================
// widths and latencies
// ====================
`define ADDR_W       7
`define PIX_W        16
`define CH_W         8
`define MEM_RD_LAT   2
// address in to registered pixel out
`define PIPE_LATENCY 3

// ====================
// display modes and gray weights
// ====================
`define MODE_W       3
`define MODE_ORIG    3'd0
`define MODE_GRAY    3'd1
`define GRAY_R_WT    76
`define GRAY_G_WT    150
`define GRAY_B_WT    26

`endif
